// ==== decodeUnit.sv ====
`timescale 1ns/10ps

module decodeUnit (
  input  logic                clk,
  input  logic                rstN,
  hazardIf.decode             hz,
  input  riscvCorePkg::wordT  instrD,
  input  riscvCorePkg::wordT  pcD,
  input  logic                validD,
  input  riscvCorePkg::wbT    wb,
  output riscvCorePkg::decExT decE,
  output logic                validE
);
  import riscvCorePkg::*;

  opcodeT opcode;
  logic [2:0] funct3;
  regAdrT rs1, rs2, rd;
  wordT immI, immS, immB, immJ, immU;
  aluOpT aluSel;
  logic aluKnown;
  wordT rs1Val, rs2Val;
  wordT regs [32];
  decExT decNext;

  assign opcode = opcodeT'(instrD[6:0]);
  assign funct3 = instrD[14:12];
  assign rs1    = instrD[19:15];
  assign rs2    = instrD[24:20];
  assign rd     = instrD[11:7];

  assign immI = {{20{instrD[31]}}, instrD[31:20]};
  assign immS = {{20{instrD[31]}}, instrD[31:25], instrD[11:7]};
  assign immB = {{19{instrD[31]}}, instrD[31], instrD[7], instrD[30:25], instrD[11:8], 1'b0};
  assign immJ = {{11{instrD[31]}}, instrD[31], instrD[19:12], instrD[20], instrD[30:21], 1'b0};
  assign immU = {instrD[31:12], 12'b0};

  // funct3 to alu op, shifts and unsigned compares fall out as unknown
  always_comb begin
    aluKnown = 1'b1;
    case (funct3)
      3'b000:  aluSel = (opcode == op && instrD[30]) ? aluSub : aluAdd;
      3'b010:  aluSel = aluSlt;
      3'b100:  aluSel = aluXor;
      3'b110:  aluSel = aluOr;
      3'b111:  aluSel = aluAnd;
      default: begin
        aluSel   = aluAdd;
        aluKnown = 1'b0;
      end
    endcase
  end

  ////////////////////////////////////////////////////////////
  // register file, x0 stays zero
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      regs <= '{default: '0};
    end else if (wb.regWrite && wb.rd != '0) begin
      regs[wb.rd] <= wb.data;
    end
  end

  // write-through so W results are seen in D the same cycle
  assign rs1Val = (rs1 == '0) ? '0 : (wb.regWrite && wb.rd == rs1) ? wb.data : regs[rs1];
  assign rs2Val = (rs2 == '0) ? '0 : (wb.regWrite && wb.rd == rs2) ? wb.data : regs[rs2];

  assign hz.rs1D = rs1;
  assign hz.rs2D = rs2;

  always_comb begin
    decNext       = '0;
    decNext.pc    = pcD;
    decNext.opA   = rs1Val;
    decNext.opB   = rs2Val;
    decNext.rs1   = rs1;
    decNext.rs2   = rs2;
    decNext.rd    = rd;
    decNext.aluOp = aluAdd;  // address add for loads and stores
    if (validD) begin
      case (opcode)
        opImm: begin
          decNext.imm      = immI;
          decNext.useImm   = 1'b1;
          decNext.aluOp    = aluSel;
          decNext.regWrite = aluKnown;
        end
        op: begin
          decNext.aluOp    = aluSel;
          decNext.regWrite = aluKnown;
        end
        lui: begin
          decNext.imm      = immU;
          decNext.useImm   = 1'b1;
          decNext.aluOp    = aluPassB;
          decNext.regWrite = 1'b1;
        end
        load: begin
          decNext.imm      = immI;
          decNext.useImm   = 1'b1;
          decNext.regWrite = (funct3 == 3'b010);  // lw only
          decNext.isLoad   = (funct3 == 3'b010);
        end
        store: begin
          decNext.imm      = immS;
          decNext.useImm   = 1'b1;
          decNext.isStore  = (funct3 == 3'b010);
        end
        branch: begin
          decNext.imm        = immB;
          decNext.isBranch   = (funct3[2:1] == 2'b00);  // beq, bne
          decNext.branchOnNe = funct3[0];
        end
        jal: begin
          decNext.imm      = immJ;
          decNext.regWrite = 1'b1;
          decNext.isJal    = 1'b1;
        end
        default: ;  // no-op
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // decode to execute register
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      decE   <= '0;
      validE <= 1'b0;
    end else if (hz.flushE) begin
      decE   <= '0;  // bubble
      validE <= 1'b0;
    end else if (!hz.stallE) begin
      decE   <= decNext;
      validE <= validD;
    end else begin
      // held in E while W drains, keep operands current
      if (wb.regWrite && wb.rd != '0 && wb.rd == decE.rs1) decE.opA <= wb.data;
      if (wb.regWrite && wb.rd != '0 && wb.rd == decE.rs2) decE.opB <= wb.data;
    end
  end

endmodule

// ==== executeUnit.sv ====
`timescale 1ns/10ps

module executeUnit (
  input  logic                clk,
  input  logic                rstN,
  hazardIf.execute            hz,
  input  riscvCorePkg::decExT decE,
  input  logic                validE,
  input  riscvCorePkg::wbT    wb,
  output riscvCorePkg::exMemT exM,
  output logic                validM,
  output logic                branchTakenE,
  output riscvCorePkg::wordT  branchTargetE
);
  import riscvCorePkg::*;

  wordT srcA, srcB, aluB, aluRes;
  exMemT exNext;

  // M first, then W, then the value read in D
  function automatic wordT forward(regAdrT rs, wordT rfVal, exMemT m, wbT w);
    if (rs != '0 && m.regWrite && !m.isLoad && m.rd == rs) return m.result;
    if (rs != '0 && w.regWrite && w.rd == rs) return w.data;
    return rfVal;
  endfunction

  assign srcA = forward(decE.rs1, decE.opA, exM, wb);
  assign srcB = forward(decE.rs2, decE.opB, exM, wb);
  assign aluB = decE.useImm ? decE.imm : srcB;

  always_comb begin
    case (decE.aluOp)
      aluAdd:   aluRes = srcA + aluB;
      aluSub:   aluRes = srcA - aluB;
      aluAnd:   aluRes = srcA & aluB;
      aluOr:    aluRes = srcA | aluB;
      aluXor:   aluRes = srcA ^ aluB;
      aluSlt:   aluRes = {31'b0, $signed(srcA) < $signed(aluB)};
      aluPassB: aluRes = aluB;
      default:  aluRes = srcA + aluB;
    endcase
  end

  ////////////////////////////////////////////////////////////
  // branch resolution
  ////////////////////////////////////////////////////////////

  assign branchTakenE  = validE &
                         ((decE.isBranch & ((srcA == srcB) ^ decE.branchOnNe)) | decE.isJal);
  assign branchTargetE = decE.pc + decE.imm;

  assign hz.rdE          = decE.rd;
  assign hz.isLoadE      = validE & decE.isLoad;
  assign hz.branchTakenE = branchTakenE;

  always_comb begin
    exNext.result    = decE.isJal ? decE.pc + 32'd4 : aluRes;  // link value
    exNext.storeData = srcB;
    exNext.rd        = decE.rd;
    exNext.regWrite  = validE & decE.regWrite;
    exNext.isLoad    = validE & decE.isLoad;
    exNext.isStore   = validE & decE.isStore;
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      exM    <= '0;
      validM <= 1'b0;
    end else if (!hz.stallM) begin
      exM    <= exNext;
      validM <= validE;
    end
  end

endmodule

// ==== fetchUnit.sv ====
`timescale 1ns/10ps

module fetchUnit #(
  parameter riscvCorePkg::wordT resetPc = '0
) (
  input  logic               clk,
  input  logic               rstN,
  hazardIf.fetch             hz,
  input  logic               branchTakenE,
  input  riscvCorePkg::wordT branchTargetE,
  output riscvCorePkg::wordT imemAdr,
  input  riscvCorePkg::wordT imemData,
  output riscvCorePkg::wordT instrD,
  output riscvCorePkg::wordT pcD,
  output logic               validD
);
  import riscvCorePkg::*;

  wordT pcF;

  // pc only moves when fetch is not held, a held branch redirects later
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      pcF <= resetPc;
    end else if (!hz.stallF) begin
      pcF <= branchTakenE ? branchTargetE : pcF + 32'd4;
    end
  end

  assign imemAdr = pcF;  // instruction comes back same cycle

  ////////////////////////////////////////////////////////////
  // fetch to decode register
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      validD <= 1'b0;
    end else if (hz.flushD) begin
      validD <= 1'b0;      // killed by taken branch
    end else if (!hz.stallD) begin
      validD <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (!hz.stallD) begin
      instrD <= imemData;
      pcD    <= pcF;
    end
  end

endmodule

// ==== hazardIf.sv ====
`timescale 1ns/10ps

interface hazardIf;
  import riscvCorePkg::*;

  // hazard sources
  regAdrT rs1D, rs2D;
  regAdrT rdE;
  logic   isLoadE;
  logic   branchTakenE;
  logic   memBusyM;

  // stall and flush controls
  logic   stallF, stallD, stallE, stallM;
  logic   flushD, flushE, flushW;

  modport hazard (
    input  rs1D, rs2D, rdE, isLoadE, branchTakenE, memBusyM,
    output stallF, stallD, stallE, stallM, flushD, flushE, flushW
  );
  modport fetch   (input stallF, stallD, flushD);
  modport decode  (output rs1D, rs2D, input stallE, flushE);
  modport execute (output rdE, isLoadE, branchTakenE, input stallM);
  modport lsu     (output memBusyM, input flushW);

endinterface

// ==== hazardUnit.sv ====
`timescale 1ns/10ps

module hazardUnit (
  hazardIf.hazard hz
);

  logic loadUse;

  // consumer sits in D right behind a load in E
  assign loadUse = hz.isLoadE && hz.rdE != '0 &&
                   (hz.rdE == hz.rs1D || hz.rdE == hz.rs2D);

  always_comb begin
    if (hz.memBusyM) begin
      // back-pressure freezes everything up to M
      hz.stallF = 1'b1;
      hz.stallD = 1'b1;
      hz.stallE = 1'b1;
      hz.stallM = 1'b1;
      hz.flushD = 1'b0;
      hz.flushE = 1'b0;
      hz.flushW = 1'b1;
    end else begin
      hz.stallF = loadUse;
      hz.stallD = loadUse;
      hz.stallE = 1'b0;
      hz.stallM = 1'b0;
      hz.flushD = hz.branchTakenE;            // kill the instr in F
      hz.flushE = hz.branchTakenE | loadUse;  // kill D, or bubble for load-use
      hz.flushW = 1'b0;
    end
  end

endmodule

// ==== loadStoreUnit.sv ====
`timescale 1ns/10ps

module loadStoreUnit (
  input  logic                clk,
  input  logic                rstN,
  hazardIf.lsu                hz,
  input  riscvCorePkg::exMemT exM,
  input  logic                validM,
  output logic                dmemValid,
  output logic                dmemWrite,
  output riscvCorePkg::wordT  dmemAdr,
  output riscvCorePkg::wordT  dmemWdata,
  input  logic                dmemReady,
  input  riscvCorePkg::wordT  dmemRdata,
  output riscvCorePkg::wbT    wb
);
  import riscvCorePkg::*;

  logic memReq;

  // M holds still while busy, so the request stays stable until accepted
  assign memReq    = validM & (exM.isLoad | exM.isStore);
  assign dmemValid = memReq;
  assign dmemWrite = memReq & exM.isStore;
  assign dmemAdr   = exM.result;
  assign dmemWdata = exM.storeData;

  assign hz.memBusyM = memReq & ~dmemReady;

  ////////////////////////////////////////////////////////////
  // memory to writeback register
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      wb <= '0;
    end else if (hz.flushW) begin
      wb.regWrite <= 1'b0;  // bubble while M waits
    end else begin
      wb.regWrite <= validM & exM.regWrite;
      wb.rd       <= exM.rd;
      wb.data     <= exM.isLoad ? dmemRdata : exM.result;  // rdata valid on accept
    end
  end

endmodule

// ==== riscvCore.f ====
riscvCorePkg.sv
hazardIf.sv
fetchUnit.sv
decodeUnit.sv
executeUnit.sv
loadStoreUnit.sv
hazardUnit.sv
riscvCore.sv
tbRiscvCore.sv

// ==== riscvCore.sv ====
`timescale 1ns/10ps

module riscvCore #(
  parameter riscvCorePkg::wordT resetPc = '0
) (
  input  logic               clk,
  input  logic               rstN,
  // instruction port
  output riscvCorePkg::wordT imemAdr,
  input  riscvCorePkg::wordT imemData,
  // data port
  output logic               dmemValid,
  output logic               dmemWrite,
  output riscvCorePkg::wordT dmemAdr,
  output riscvCorePkg::wordT dmemWdata,
  input  logic               dmemReady,
  input  riscvCorePkg::wordT dmemRdata
);
  import riscvCorePkg::*;

  wordT  instrD, pcD;
  logic  validD, validE, validM;
  logic  branchTakenE;
  wordT  branchTargetE;
  decExT decE;
  exMemT exM;
  wbT    wb;

  hazardIf hz ();

  fetchUnit #(.resetPc(resetPc)) uFetch (
    .clk, .rstN, .hz,
    .branchTakenE, .branchTargetE,
    .imemAdr, .imemData,
    .instrD, .pcD, .validD
  );

  decodeUnit uDecode (
    .clk, .rstN, .hz,
    .instrD, .pcD, .validD,
    .wb,          // register write
    .decE, .validE
  );

  executeUnit uExecute (
    .clk, .rstN, .hz,
    .decE, .validE,
    .wb,          // forwarding from W
    .exM, .validM,
    .branchTakenE, .branchTargetE
  );

  loadStoreUnit uLsu (
    .clk, .rstN, .hz,
    .exM, .validM,
    .dmemValid, .dmemWrite, .dmemAdr, .dmemWdata,
    .dmemReady, .dmemRdata,
    .wb
  );

  // global stall and flush control
  hazardUnit uHazard (.hz);

endmodule

// ==== riscvCorePkg.sv ====
package riscvCorePkg;

  ////////////////////////////////////////////////////////////
  // widths and basic types
  ////////////////////////////////////////////////////////////

  localparam int xlen = 32;

  typedef logic [4:0]      regAdrT;
  typedef logic [xlen-1:0] wordT;

  // major opcodes that the core executes, anything else is a no-op
  typedef enum logic [6:0] {
    opImm  = 7'b0010011,
    op     = 7'b0110011,
    lui    = 7'b0110111,
    load   = 7'b0000011,
    store  = 7'b0100011,
    branch = 7'b1100011,
    jal    = 7'b1101111
  } opcodeT;

  typedef enum logic [2:0] {
    aluAdd,
    aluSub,
    aluAnd,
    aluOr,
    aluXor,
    aluSlt,
    aluPassB  // lui
  } aluOpT;

  ////////////////////////////////////////////////////////////
  // stage payloads
  ////////////////////////////////////////////////////////////

  typedef struct packed {
    wordT   pc;
    wordT   opA;         // rs1 value from register file
    wordT   opB;         // rs2 value from register file
    wordT   imm;
    regAdrT rs1;
    regAdrT rs2;
    regAdrT rd;
    aluOpT  aluOp;
    logic   useImm;      // alu b input takes imm
    logic   regWrite;
    logic   isLoad;
    logic   isStore;
    logic   isBranch;
    logic   branchOnNe;  // bne, else beq
    logic   isJal;
  } decExT;

  typedef struct packed {
    wordT   result;      // alu result, address or link value
    wordT   storeData;
    regAdrT rd;
    logic   regWrite;
    logic   isLoad;
    logic   isStore;
  } exMemT;

  typedef struct packed {
    logic   regWrite;
    regAdrT rd;
    wordT   data;
  } wbT;

endpackage

// ==== tbRiscvCore.sv ====
`timescale 1ns/10ps

module tbRiscvCore;

  localparam int          imemWords   = 64;
  localparam int          dmemWords   = 256;
  localparam logic [31:0] markerAdr   = 32'h3fc;  // last data word, ends a program
  localparam int          resetCycles = 8;
  localparam int          worstCpi    = 6;  // 3-cycle ready wait plus load-use and flushes
  localparam int          numTests    = 5;
  localparam int          watchdogCycles =
    numTests * (resetCycles + 20 + imemWords * worstCpi);
  localparam logic [6:0]  opImmC = 7'b0010011;
  localparam logic [6:0]  loadC  = 7'b0000011;
  localparam logic [31:0] nop    = 32'h00000013;  // addi x0, x0, 0

  logic        clk, rstN;
  logic [31:0] imemAdr, imemData;
  logic        dmemValid, dmemWrite, dmemReady;
  logic [31:0] dmemAdr, dmemWdata, dmemRdata;

  logic [31:0] imem [imemWords];
  logic [31:0] dmem [dmemWords];
  logic [31:0] storeAdrQ [$];   // accepted stores
  logic [31:0] storeDataQ [$];
  logic [31:0] wantAdrQ [$];    // stores the program should make
  logic [31:0] wantDataQ [$];
  int          progLen, nextOff;
  bit          markerSeen, randomReady;
  int          waitLeft;
  int          errors, checks, tests;
  int unsigned rngSeed;
  bit          pending;         // request raised, not yet accepted
  logic [31:0] heldAdr, heldWdata;
  logic        heldWrite;

  riscvCore #(.resetPc(32'h0)) riscvCore_i (
    .clk, .rstN,
    .imemAdr, .imemData,
    .dmemValid, .dmemWrite, .dmemAdr, .dmemWdata,
    .dmemReady, .dmemRdata
  );

  assign imemData  = imem[imemAdr[7:2]];   // combinational instruction read
  assign dmemRdata = dmem[dmemAdr[9:2]];   // valid in the accepting cycle

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  ////////////////////////////////////////////////////////////
  // instruction encoding
  ////////////////////////////////////////////////////////////

  function automatic logic [31:0] rType(input logic [6:0] f7, input logic [2:0] f3,
                                        input int rd, input int rs1, input int rs2);
    return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], 7'b0110011};
  endfunction

  function automatic logic [31:0] iType(input logic [6:0] opc, input logic [2:0] f3,
                                        input int rd, input int rs1, input int imm);
    return {imm[11:0], rs1[4:0], f3, rd[4:0], opc};
  endfunction

  function automatic logic [31:0] sType(input int rs2, input int rs1, input int imm);
    return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'b0100011};  // sw
  endfunction

  function automatic logic [31:0] bType(input logic [2:0] f3, input int rs1, input int rs2,
                                        input int off);
    return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3, off[4:1], off[11], 7'b1100011};
  endfunction

  function automatic logic [31:0] jType(input int rd, input int off);
    return {off[20], off[10:1], off[11], off[19:12], rd[4:0], 7'b1101111};
  endfunction

  function automatic logic [31:0] uType(input int rd, input logic [19:0] imm);
    return {imm, rd[4:0], 7'b0110111};
  endfunction

  ////////////////////////////////////////////////////////////
  // data memory model and store monitor
  ////////////////////////////////////////////////////////////

  initial begin
    dmemReady = 1'b1;
    waitLeft  = -1;
    rngSeed   = 92596;
    void'($urandom(rngSeed));
    forever begin
      @(posedge clk);
      if (!rstN || (dmemValid && dmemReady)) waitLeft = -1;  // accepted, next one is new
      #1;
      if (!randomReady) begin
        dmemReady = 1'b1;
      end else if (!dmemValid) begin
        dmemReady = 1'b0;
      end else begin
        if (waitLeft < 0) waitLeft = $urandom % 4;  // 0 to 3 cycles
        dmemReady = (waitLeft == 0);
        if (waitLeft > 0) waitLeft--;
      end
    end
  end

  always @(posedge clk) begin
    if (!rstN) begin
      pending = 1'b0;
    end else if (dmemValid) begin
      if (pending) begin
        // request must not move while it waits
        check("dmemAdr", dmemAdr, heldAdr);
        check("dmemWdata", dmemWdata, heldWdata);
        check("dmemWrite", dmemWrite, heldWrite);
      end
      if (!dmemReady) begin
        if (!pending) begin
          heldAdr   = dmemAdr;
          heldWdata = dmemWdata;
          heldWrite = dmemWrite;
        end
        pending = 1'b1;
      end else begin
        pending = 1'b0;
        if (dmemWrite) begin
          dmem[dmemAdr[9:2]] <= dmemWdata;
          if (dmemAdr == markerAdr) begin
            markerSeen = 1'b1;
          end else begin
            storeAdrQ.push_back(dmemAdr);
            storeDataQ.push_back(dmemWdata);
          end
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////////////

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      $display("** Error %s: got 0x%h, expected 0x%h", name, got, exp);
      errors++;
    end
  endtask

  task automatic put(input logic [31:0] instr);
    imem[progLen] = instr;
    progLen++;
  endtask

  // sw rs to the next result slot, and note what it should hold
  task automatic storeResult(input int rs, input logic [31:0] value);
    put(sType(rs, 0, nextOff));
    wantAdrQ.push_back(nextOff);
    wantDataQ.push_back(value);
    nextOff += 4;
  endtask

  // core held in reset while the program is written
  task automatic startProgram();
    int i;
    rstN = 1'b0;
    for (i = 0; i < imemWords; i++) imem[i] = nop;
    progLen    = 0;
    nextOff    = 0;
    markerSeen = 1'b0;
    storeAdrQ.delete();
    storeDataQ.delete();
    wantAdrQ.delete();
    wantDataQ.delete();
  endtask

  task automatic compareStores();
    int i;
    int n;
    check("store count", storeAdrQ.size(), wantAdrQ.size());
    n = (storeAdrQ.size() < wantAdrQ.size()) ? storeAdrQ.size() : wantAdrQ.size();
    for (i = 0; i < n; i++) begin
      check("dmemAdr", storeAdrQ[i], wantAdrQ[i]);
      check("dmemWdata", storeDataQ[i], wantDataQ[i]);
    end
  endtask

  task automatic runProgram(input int num, input string name, input bit rnd);
    int errStart;
    int cycles;
    int limit;
    put(sType(0, 0, markerAdr));  // end of program
    errStart    = errors;
    limit       = progLen * worstCpi + 20;
    randomReady = rnd;
    repeat (resetCycles) @(posedge clk);
    #1 rstN = 1'b1;
    check("dmemValid", dmemValid, 1'b0);
    check("imemAdr", imemAdr, 32'h0);
    cycles = 0;
    while (!markerSeen && cycles < limit) begin
      @(posedge clk);
      #1;
      cycles++;
    end
    if (!markerSeen) begin
      $display("test %0d %s: no store to the marker address within %0d cycles",
               num, name, limit);
      errors++;
    end else begin
      compareStores();
    end
    tests++;
    $display("test %0d %s: %0d errors", num, name, errors - errStart);
  endtask

  ////////////////////////////////////////////////////////////
  // directed tests
  ////////////////////////////////////////////////////////////

  task automatic buildAluProgram();
    logic [31:0] a;
    logic [31:0] b;
    a = 32'h123;
    b = 32'hffffffbb;  // -69
    put(iType(opImmC, 3'b000, 1, 0, 'h123));
    put(iType(opImmC, 3'b000, 2, 0, -69));
    put(rType(7'h00, 3'b000, 3, 1, 2));  // add
    storeResult(3, a + b);
    put(rType(7'h20, 3'b000, 4, 1, 2));  // sub
    storeResult(4, a - b);
    put(rType(7'h00, 3'b111, 5, 1, 2));
    storeResult(5, a & b);
    put(rType(7'h00, 3'b110, 6, 1, 2));
    storeResult(6, a | b);
    put(rType(7'h00, 3'b100, 7, 1, 2));
    storeResult(7, a ^ b);
    put(rType(7'h00, 3'b010, 8, 2, 1));  // slt, negative < positive
    storeResult(8, ($signed(b) < $signed(a)) ? 32'd1 : 32'd0);
    put(rType(7'h00, 3'b010, 9, 1, 2));
    storeResult(9, ($signed(a) < $signed(b)) ? 32'd1 : 32'd0);
    put(iType(opImmC, 3'b111, 10, 1, 'h0f0));
    storeResult(10, a & 32'h0f0);
    put(iType(opImmC, 3'b110, 11, 2, 'h300));
    storeResult(11, b | 32'h300);
    put(iType(opImmC, 3'b100, 12, 1, -1));  // xori with all ones
    storeResult(12, ~a);
    put(iType(opImmC, 3'b010, 13, 2, 5));
    storeResult(13, ($signed(b) < 5) ? 32'd1 : 32'd0);
    put(uType(14, 20'habcde));
    storeResult(14, 32'habcde000);
  endtask

  task automatic aluTest();
    startProgram();
    buildAluProgram();
    runProgram(1, "alu ops", 1'b0);
  endtask

  task automatic forwardTest();
    startProgram();
    put(iType(opImmC, 3'b000, 1, 0, 5));
    put(iType(opImmC, 3'b000, 2, 1, 3));   // distance 1, from M
    put(iType(opImmC, 3'b000, 3, 1, 10));  // distance 2, from W
    put(iType(opImmC, 3'b000, 4, 1, -1));  // distance 3, write-through
    put(rType(7'h00, 3'b000, 5, 4, 3));
    put(rType(7'h00, 3'b100, 6, 5, 2));
    put(iType(opImmC, 3'b000, 7, 0, 1));
    put(iType(opImmC, 3'b000, 7, 7, 1));
    put(iType(opImmC, 3'b000, 7, 7, 1));
    storeResult(2, 5 + 3);
    storeResult(3, 5 + 10);
    storeResult(4, 5 - 1);
    storeResult(5, 4 + 15);
    storeResult(6, 19 ^ 8);
    storeResult(7, 3);
    runProgram(2, "forwarding", 1'b0);
  endtask

  task automatic loadUseTest();
    startProgram();
    put(iType(opImmC, 3'b000, 1, 0, 'h55));
    put(iType(opImmC, 3'b000, 4, 0, 'h11));
    storeResult(1, 'h55);                     // word 0
    put(iType(loadC, 3'b010, 2, 0, 0));       // lw x2, 0(x0)
    put(rType(7'h00, 3'b000, 3, 2, 4));       // uses x2 right away
    storeResult(3, 'h55 + 'h11);
    put(iType(loadC, 3'b010, 5, 0, 0));
    storeResult(5, 'h55);                     // load feeds store data
    runProgram(3, "load-use", 1'b0);
  endtask

  task automatic branchTest();
    int jalAdr;
    startProgram();
    put(iType(opImmC, 3'b000, 1, 0, 3));
    put(iType(opImmC, 3'b000, 2, 0, 3));
    put(iType(opImmC, 3'b000, 3, 0, 9));
    put(iType(opImmC, 3'b000, 9, 0, 'h77));
    put(bType(3'b000, 1, 2, 12));  // beq taken
    put(sType(9, 0, 'h100));       // shadow slots
    put(sType(9, 0, 'h104));
    put(bType(3'b001, 1, 2, 12));  // bne not taken
    storeResult(1, 3);
    storeResult(3, 9);
    put(bType(3'b000, 1, 3, 12));  // beq not taken
    storeResult(2, 3);
    storeResult(9, 'h77);
    put(bType(3'b001, 1, 3, 12));  // bne taken
    put(sType(9, 0, 'h108));
    put(sType(9, 0, 'h10c));
    jalAdr = progLen * 4;
    put(jType(5, 12));
    put(sType(9, 0, 'h110));
    put(sType(9, 0, 'h114));
    storeResult(5, jalAdr + 4);    // link value
    runProgram(4, "branches", 1'b0);
  endtask

  task automatic backPressureTest();
    startProgram();
    buildAluProgram();
    runProgram(5, "alu ops, random ready", 1'b1);
  endtask

  initial begin
    int i;
    rstN        = 1'b0;
    randomReady = 1'b0;
    markerSeen  = 1'b0;
    pending     = 1'b0;
    errors      = 0;
    checks      = 0;
    tests       = 0;
    progLen     = 0;
    nextOff     = 0;
    for (i = 0; i < imemWords; i++) imem[i] = nop;
    for (i = 0; i < dmemWords; i++) dmem[i] = 32'hd0000000 | (i << 2);
    aluTest();
    forwardTest();
    loadUseTest();
    branchTest();
    backPressureTest();
    $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

  // watchdog, bound by the longest program at worst cpi
  initial begin
    #(watchdogCycles * 100);
    $display("watchdog expired after %0d cycles, run stopped", watchdogCycles);
    $display("Checks failed");
    $finish;
  end

endmodule
